//--- hw/ucodeFormatPkg.sv
// Microcode load file format: character codes, field widths and token enums
package ucodeFormatPkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // One ASCIIized field carries six bits of a word
  localparam int fieldBits = 6;
  // Decoded load word, PDP-11 sized
  localparam int loadWordBits = 16;
  // Input characters are 7-bit ASCII
  localparam int charBits = 7;

  //////////////////////////////////////////////////
  // Character codes
  //////////////////////////////////////////////////

  localparam logic [charBits-1:0] chCr = 7'h0d;
  localparam logic [charBits-1:0] chLf = 7'h0a;
  localparam logic [charBits-1:0] chComma = 7'h2c;
  localparam logic [charBits-1:0] chSemi = 7'h3b;
  localparam logic [charBits-1:0] chLetterZ = 7'h5a;
  localparam logic [charBits-1:0] chLetterC = 7'h43;
  localparam logic [charBits-1:0] chLetterD = 7'h44;
  // ASCIIized data occupies octal 075 through 174
  localparam logic [charBits-1:0] chDataLo = 7'o075;
  localparam logic [charBits-1:0] chDataHi = 7'o174;

  //////////////////////////////////////////////////
  // Token and record types
  //////////////////////////////////////////////////

  // What the classifier made of one character
  typedef enum logic [2:0] {
    kindData,
    kindComma,
    kindEol,
    kindType,
    kindIgnore
  } charKindT;

  // Record type from the first character of a line
  typedef enum logic [2:0] {
    recNone,
    recZero,
    recCram,
    recDram,
    recComment,
    recBad
  } recTypeT;

  typedef logic [loadWordBits-1:0] loadWordT;

endpackage

//--- hw/ramMapPkg.sv
// CRAM and DRAM geometry and placement of load words into RAM entries
package ramMapPkg;

  //////////////////////////////////////////////////
  // Control RAM
  //////////////////////////////////////////////////

  // 80 data bits plus the CALL/DISP special field
  localparam int cramBits = 86;
  localparam int cramAdrBits = 11;
  // Load words per CRAM location
  localparam int cramWordsPerEntry = 6;

  typedef logic [cramBits-1:0] cramEntryT;
  typedef logic [cramAdrBits-1:0] cramAdrT;

  //////////////////////////////////////////////////
  // Dispatch RAM
  //////////////////////////////////////////////////

  localparam int dramAdrBits = 8;
  // Even, odd and common word per location pair
  localparam int dramWordsPerPair = 3;
  // A(3) B(3) P(1) J1-J4 J7 J8-J10
  localparam int dramEntryBits = 15;

  typedef logic [dramAdrBits-1:0] dramAdrT;
  typedef logic [dramEntryBits-1:0] dramEntryT;

  // Field positions inside the even and odd load words
  localparam int dramAHi = 13;
  localparam int dramALo = 11;
  localparam int dramBHi = 10;
  localparam int dramBLo = 8;
  localparam int dramParBit = 5;
  localparam int dramJLowHi = 2;
  localparam int dramJLowLo = 0;
  // J7 is common to the pair but written by the odd word
  localparam int dramJ7Bit = 3;
  // J1-J4 come from the common word
  localparam int dramJComHi = 3;
  localparam int dramJComLo = 0;

endpackage

//--- hw/charClassifier.sv
// Load file stage 1: sorts characters into tokens and decodes field values
`timescale 1ns/1ps

module charClassifier (
  input  logic                                clk,
  input  logic                                rstN,
  input  logic                                charValid,
  input  logic [ucodeFormatPkg::charBits-1:0] charIn,
  output logic                                kindValid,
  output ucodeFormatPkg::charKindT            charKind,
  output logic [ucodeFormatPkg::fieldBits-1:0] fieldValue,
  output ucodeFormatPkg::recTypeT             recType
);
  import ucodeFormatPkg::*;

  // Line tracking
  logic atLineStart;
  logic inComment;
  logic afterCr;
  recTypeT lineType;

  logic isEol;
  charKindT nextKind;
  recTypeT typeOfChar;

  assign isEol = (charIn == chCr) || (charIn == chLf);

  // Record letter decode
  always_comb begin
    case (charIn)
      chLetterZ: typeOfChar = recZero;
      chLetterC: typeOfChar = recCram;
      chLetterD: typeOfChar = recDram;
      chSemi:    typeOfChar = recComment;
      default:   typeOfChar = recBad;
    endcase
  end

  // Token kind, line end has priority over everything
  always_comb begin
    if (isEol) begin
      // LF right after CR is the same line end
      nextKind = (afterCr && charIn == chLf) ? kindIgnore : kindEol;
    end else if (atLineStart) begin
      nextKind = kindType;
    end else if (inComment) begin
      nextKind = kindIgnore;
    end else if (charIn == chComma) begin
      nextKind = kindComma;
    end else if (charIn >= chDataLo && charIn <= chDataHi) begin
      nextKind = kindData;
    end else begin
      // Separator space and anything else
      nextKind = kindIgnore;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      kindValid <= 1'b0;
      atLineStart <= 1'b1;
      inComment <= 1'b0;
      afterCr <= 1'b0;
      lineType <= recNone;
      recType <= recNone;
    end else begin
      kindValid <= charValid;
      // One stage later than the tokens, so it lines up with assembled words
      recType <= lineType;
      if (charValid) begin
        afterCr <= (charIn == chCr);
        if (isEol) begin
          atLineStart <= 1'b1;
          inComment <= 1'b0;
        end else if (atLineStart) begin
          atLineStart <= 1'b0;
          lineType <= typeOfChar;
          inComment <= (typeOfChar == recComment);
        end
      end
    end
  end

  // Token payload
  always_ff @(posedge clk) begin
    if (charValid) begin
      charKind <= nextKind;
      // Low six bits undo the ASCIIizing offset
      fieldValue <= charIn[fieldBits-1:0];
    end
  end

endmodule

//--- hw/fieldAssembler.sv
// Load file stage 2: builds 16-bit load words from 6-bit field characters
`timescale 1ns/1ps

module fieldAssembler (
  input  logic                                 clk,
  input  logic                                 rstN,
  input  logic                                 kindValid,
  input  ucodeFormatPkg::charKindT             charKind,
  input  logic [ucodeFormatPkg::fieldBits-1:0] fieldValue,
  output logic                                 wordValid,
  output ucodeFormatPkg::loadWordT             loadWord,
  output logic                                 lastWord
);
  import ucodeFormatPkg::*;

  // Word being shifted together
  loadWordT acc;
  // Set inside a line, a comma opens the next field
  logic fieldOpen;

  logic isClose;
  logic closeField;
  logic isEolTok;

  //////////////////////////////////////////////////
  // Field end detect
  //////////////////////////////////////////////////

  assign isEolTok = (charKind == kindEol);
  assign isClose = (charKind == kindComma) || isEolTok;
  // Empty field still closes, acc is zero then
  assign closeField = kindValid && isClose && fieldOpen;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wordValid <= 1'b0;
      fieldOpen <= 1'b0;
      acc <= '0;
    end else begin
      wordValid <= closeField;
      if (kindValid) begin
        case (charKind)
          kindType: begin
            // Record letter starts the first field
            fieldOpen <= 1'b1;
            acc <= '0;
          end
          kindData: begin
            // Most significant field arrives first
            acc <= {acc[loadWordBits-fieldBits-1:0], fieldValue};
          end
          kindComma, kindEol: begin
            acc <= '0;
            // Line end closes everything until the next record letter
            if (isEolTok) begin
              fieldOpen <= 1'b0;
            end
          end
          default: begin
            // Ignored characters leave the field alone
            acc <= acc;
          end
        endcase
      end
    end
  end

  //////////////////////////////////////////////////
  // Word out
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (closeField) begin
      loadWord <= acc;
      lastWord <= isEolTok;
    end
  end

endmodule

//--- hw/recordParser.sv
// Load file stage 3: walks the fields of a line and issues CRAM and DRAM writes
`timescale 1ns/1ps

module recordParser (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      wordValid,
  input  ucodeFormatPkg::loadWordT  loadWord,
  input  logic                      lastWord,
  input  ucodeFormatPkg::recTypeT   recType,
  output logic                      cramWe,
  output ramMapPkg::cramAdrT        cramAdr,
  output ramMapPkg::cramEntryT      cramData,
  output logic                      dramWe,
  output ramMapPkg::dramAdrT        dramAdr,
  output ramMapPkg::dramEntryT      dramEven,
  output ramMapPkg::dramEntryT      dramOdd,
  output logic                      lineDone,
  output logic                      lineErr
);
  import ucodeFormatPkg::*;
  import ramMapPkg::*;

  typedef enum logic [2:0] {
    stWordCount,
    stAddress,
    stData,
    stChecksum,
    stFlush
  } parseStateT;

  parseStateT state;

  // Running line sum, zero when checksum is good
  loadWordT sum;
  loadWordT sumNext;
  // Data words still expected
  loadWordT wordsLeft;
  // Position inside the current CRAM or DRAM group
  logic [2:0] groupPos;
  logic [2:0] groupSize;
  logic groupEnd;

  // Continuation addresses, one per RAM
  cramAdrT cramPtr;
  dramAdrT dramPtr;

  // Words of a group before the completing one
  loadWordT grp [cramWordsPerEntry-1];

  logic dataWord;
  logic cramFire;
  logic dramFire;
  logic eofLine;
  logic endErr;

  // One DRAM location from its own word, the odd word and the common word
  function automatic dramEntryT packDram(loadWordT side, loadWordT oddWord,
                                         loadWordT common);
    return {side[dramAHi:dramALo], side[dramBHi:dramBLo], side[dramParBit],
            common[dramJComHi:dramJComLo], oddWord[dramJ7Bit],
            side[dramJLowHi:dramJLowLo]};
  endfunction

  //////////////////////////////////////////////////
  // Decode of the current word
  //////////////////////////////////////////////////

  assign sumNext = sum + loadWord;

  always_comb begin
    case (recType)
      recCram: groupSize = 3'(cramWordsPerEntry);
      recDram: groupSize = 3'(dramWordsPerPair);
      // Z and others just count words
      default: groupSize = 3'd1;
    endcase
  end

  assign groupEnd = (groupPos == groupSize - 3'd1);
  assign dataWord = wordValid && (state == stData);
  assign cramFire = dataWord && groupEnd && (recType == recCram);
  assign dramFire = dataWord && groupEnd && (recType == recDram);
  // WC and ADR both zero
  assign eofLine = (wordsLeft == '0) && (loadWord == '0);

  // Line verdict, only meaningful with lastWord
  always_comb begin
    if (recType == recComment) begin
      endErr = 1'b0;
    end else begin
      // Short line, long line, bad sum, partial group or unknown letter
      endErr = (recType == recBad) || (recType == recNone) ||
               (state != stChecksum) || (sumNext != '0) || (groupPos != '0);
    end
  end

  //////////////////////////////////////////////////
  // Line FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= stWordCount;
      sum <= '0;
      wordsLeft <= '0;
      groupPos <= '0;
      cramPtr <= '0;
      dramPtr <= '0;
      cramWe <= 1'b0;
      dramWe <= 1'b0;
      lineDone <= 1'b0;
      lineErr <= 1'b0;
    end else begin
      cramWe <= cramFire;
      dramWe <= dramFire;
      lineDone <= 1'b0;
      if (wordValid) begin
        case (state)
          stWordCount: begin
            wordsLeft <= loadWord;
            state <= stAddress;
          end
          stAddress: begin
            // Zero address continues from the last line of this type
            if (recType == recCram) begin
              if (eofLine) begin
                cramPtr <= '0;
              end else if (loadWord != '0) begin
                cramPtr <= cramAdrT'(loadWord);
              end
            end
            if (recType == recDram) begin
              if (eofLine) begin
                dramPtr <= '0;
              end else if (loadWord != '0) begin
                // Pairs always start on an even location
                dramPtr <= {loadWord[dramAdrBits-1:1], 1'b0};
              end
            end
            state <= (wordsLeft == '0) ? stChecksum : stData;
          end
          stData: begin
            wordsLeft <= wordsLeft - 1'b1;
            groupPos <= groupEnd ? 3'd0 : groupPos + 3'd1;
            if (cramFire) begin
              cramPtr <= cramPtr + 1'b1;
            end
            if (dramFire) begin
              dramPtr <= dramPtr + 2'd2;
            end
            if (wordsLeft == loadWordT'(1)) begin
              state <= stChecksum;
            end
          end
          stChecksum: begin
            // More words than WC announced
            state <= stFlush;
          end
          default: begin
            state <= stFlush;
          end
        endcase
        if (lastWord) begin
          state <= stWordCount;
          sum <= '0;
          groupPos <= '0;
          lineDone <= 1'b1;
          lineErr <= endErr;
        end else begin
          sum <= sumNext;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Group collection and RAM payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (dataWord && !groupEnd) begin
      grp[groupPos] <= loadWord;
    end
    if (cramFire) begin
      cramAdr <= cramPtr;
      // 80-85 from sixth word, then 64-79 down to 0-15
      cramData <= {loadWord[cramBits-5*loadWordBits-1:0],
                   grp[0], grp[1], grp[2], grp[3], grp[4]};
    end
    if (dramFire) begin
      dramAdr <= dramPtr;
      dramEven <= packDram(grp[0], grp[1], loadWord);
      dramOdd <= packDram(grp[1], grp[1], loadWord);
    end
  end

endmodule

//--- hw/ucodeLoader.sv
// Microcode loader top: classifier, field assembler and record parser in a row
`timescale 1ns/1ps

module ucodeLoader (
  input  logic                                clk,
  input  logic                                rstN,
  input  logic                                charValid,
  input  logic [ucodeFormatPkg::charBits-1:0] charIn,
  output logic                                cramWe,
  output ramMapPkg::cramAdrT                  cramAdr,
  output ramMapPkg::cramEntryT                cramData,
  output logic                                dramWe,
  output ramMapPkg::dramAdrT                  dramAdr,
  output ramMapPkg::dramEntryT                dramEven,
  output ramMapPkg::dramEntryT                dramOdd,
  output logic                                lineDone,
  output logic                                lineErr
);
  import ucodeFormatPkg::*;

  // Classifier tokens
  logic kindValid;
  charKindT charKind;
  logic [fieldBits-1:0] fieldValue;
  recTypeT recType;

  // Assembled words
  logic wordValid;
  loadWordT loadWord;
  logic lastWord;

  charClassifier classifier (
    .clk       (clk),
    .rstN      (rstN),
    .charValid (charValid),
    .charIn    (charIn),
    .kindValid (kindValid),
    .charKind  (charKind),
    .fieldValue(fieldValue),
    .recType   (recType)
  );

  fieldAssembler assembler (
    .clk       (clk),
    .rstN      (rstN),
    .kindValid (kindValid),
    .charKind  (charKind),
    .fieldValue(fieldValue),
    .wordValid (wordValid),
    .loadWord  (loadWord),
    .lastWord  (lastWord)
  );

  // recType skips the assembler, it is already delayed to match
  recordParser parser (
    .clk      (clk),
    .rstN     (rstN),
    .wordValid(wordValid),
    .loadWord (loadWord),
    .lastWord (lastWord),
    .recType  (recType),
    .cramWe   (cramWe),
    .cramAdr  (cramAdr),
    .cramData (cramData),
    .dramWe   (dramWe),
    .dramAdr  (dramAdr),
    .dramEven (dramEven),
    .dramOdd  (dramOdd),
    .lineDone (lineDone),
    .lineErr  (lineErr)
  );

endmodule

//--- bench/loadModel.svh
// Load line generator and reference model for the microcode loader testbench
`ifndef loadModelSvh
`define loadModelSvh

// Ways to spoil a line
localparam int corNone = 0;
localparam int corSum = 1;
localparam int corWcHigh = 2;
localparam int corWcLow = 3;
localparam int corLetter = 4;

// Expected DUT outputs, oldest first
cramAdrT expCramAdr [$];
cramEntryT expCramData [$];
dramAdrT expDramAdr [$];
dramEntryT expDramEven [$];
dramEntryT expDramOdd [$];
bit expLineErr [$];

// Line under construction, as words and then as characters
loadWordT lineWords [$];
logic [charBits-1:0] lineChars [$];

// Continuation addresses the DUT should be holding
cramAdrT modelCramPtr = '0;
dramAdrT modelDramPtr = '0;

//////////////////////////////////////////////////
// ASCIIizing
//////////////////////////////////////////////////

// Values below 075 are moved up by 0100, the rest stay as they are
function automatic logic [charBits-1:0] asciiize(input logic [fieldBits-1:0] v);
  if (v < 6'o75) begin
    return {1'b0, v} + 7'o100;
  end
  return {1'b0, v};
endfunction

// One word as up to three characters, most significant first
task automatic appendField(input loadWordT w);
  int nChars;
  int i;
  if (w[15:12] != '0) begin
    nChars = 3;
  end else if (w[11:6] != '0) begin
    nChars = 2;
  end else begin
    nChars = 1;
  end
  // Sometimes keep leading zero characters
  if ($urandom % 2 == 1) begin
    nChars = 3;
  end
  // Zero may also be written as an empty field
  if (w == '0 && $urandom % 2 == 1) begin
    nChars = 0;
  end
  for (i = nChars - 1; i >= 0; i--) begin
    lineChars.push_back(asciiize(fieldBits'(w >> (fieldBits * i))));
  end
endtask

// CR LF, CR alone or LF alone
task automatic appendEol();
  case ($urandom % 3)
    0: begin
      lineChars.push_back(chCr);
      lineChars.push_back(chLf);
    end
    1: lineChars.push_back(chCr);
    default: lineChars.push_back(chLf);
  endcase
endtask

// Letter, space, comma separated words, line end
task automatic emitLine(input logic [charBits-1:0] letter);
  int i;
  lineChars.push_back(letter);
  lineChars.push_back(7'h20);
  for (i = 0; i < lineWords.size(); i++) begin
    if (i != 0) begin
      lineChars.push_back(chComma);
    end
    appendField(lineWords[i]);
  end
  appendEol();
endtask

// Checksum makes the 16-bit sum of the whole line zero
task automatic pushChecksum(input bit flip);
  loadWordT sum;
  loadWordT ck;
  sum = '0;
  foreach (lineWords[i]) begin
    sum = sum + lineWords[i];
  end
  ck = loadWordT'(0) - sum;
  if (flip) begin
    ck = ck ^ loadWordT'(1 << ($urandom % loadWordBits));
  end
  lineWords.push_back(ck);
endtask

function automatic logic [charBits-1:0] badLetter();
  case ($urandom % 4)
    0: return 7'h41;
    1: return 7'h45;
    2: return 7'h51;
    default: return 7'h58;
  endcase
endfunction

//////////////////////////////////////////////////
// RAM entry layout
//////////////////////////////////////////////////

// First data word lands highest, sixth word gives the special field
function automatic cramEntryT cramEntry(input loadWordT w0, input loadWordT w1,
                                        input loadWordT w2, input loadWordT w3,
                                        input loadWordT w4, input loadWordT w5);
  cramEntryT e;
  e[79:64] = w0;
  e[63:48] = w1;
  e[47:32] = w2;
  e[31:16] = w3;
  e[15:0] = w4;
  e[85:80] = w5[5:0];
  return e;
endfunction

// A, B, parity, J1-J4, J7, J8-J10
function automatic dramEntryT dramEntry(input loadWordT own, input loadWordT odd,
                                        input loadWordT common);
  dramEntryT e;
  e[14:12] = own[dramAHi:dramALo];
  e[11:9] = own[dramBHi:dramBLo];
  e[8] = own[dramParBit];
  e[7:4] = common[dramJComHi:dramJComLo];
  e[3] = odd[dramJ7Bit];
  e[2:0] = own[dramJLowHi:dramJLowLo];
  return e;
endfunction

//////////////////////////////////////////////////
// Line builders
//////////////////////////////////////////////////

// C or D line with its predicted writes and status
task automatic buildRamLine(input recTypeT kind, input int groups, input bit contAdr,
                            input int corrupt);
  int gsize;
  int nData;
  int wc;
  int okGroups;
  int g;
  int b;
  loadWordT adr;
  loadWordT data [$];
  gsize = (kind == recCram) ? cramWordsPerEntry : dramWordsPerPair;
  nData = groups * gsize;
  wc = nData;
  okGroups = groups;
  // Short WC cuts the line after whole groups, long WC eats the checksum
  if (corrupt == corWcLow && groups > 1) begin
    wc = nData - gsize;
    okGroups = groups - 1;
  end else if (corrupt == corWcLow || corrupt == corWcHigh) begin
    wc = nData + gsize;
  end
  if (contAdr) begin
    adr = '0;
  end else if (kind == recCram) begin
    adr = loadWordT'(1 + $urandom % ((1 << cramAdrBits) - 1));
  end else begin
    adr = loadWordT'(2 * (1 + $urandom % ((1 << (dramAdrBits - 1)) - 1)));
  end
  repeat (nData) begin
    data.push_back(loadWordT'($urandom));
  end
  lineWords.delete();
  lineWords.push_back(loadWordT'(wc));
  lineWords.push_back(adr);
  foreach (data[i]) begin
    lineWords.push_back(data[i]);
  end
  pushChecksum(corrupt == corSum);
  if (corrupt == corLetter) begin
    emitLine(badLetter());
  end else if (kind == recCram) begin
    emitLine(chLetterC);
  end else begin
    emitLine(chLetterD);
  end
  // Unknown letter writes nothing and leaves the addresses alone
  if (corrupt != corLetter && kind == recCram) begin
    if (adr != '0) begin
      modelCramPtr = cramAdrT'(adr);
    end
    for (g = 0; g < okGroups; g++) begin
      b = g * cramWordsPerEntry;
      expCramAdr.push_back(modelCramPtr);
      expCramData.push_back(cramEntry(data[b], data[b+1], data[b+2], data[b+3],
                                      data[b+4], data[b+5]));
      modelCramPtr = modelCramPtr + 1'b1;
    end
  end else if (corrupt != corLetter) begin
    if (adr != '0) begin
      modelDramPtr = dramAdrT'(adr);
    end
    for (g = 0; g < okGroups; g++) begin
      b = g * dramWordsPerPair;
      expDramAdr.push_back(modelDramPtr);
      expDramEven.push_back(dramEntry(data[b], data[b+1], data[b+2]));
      expDramOdd.push_back(dramEntry(data[b+1], data[b+1], data[b+2]));
      modelDramPtr = modelDramPtr + 2'd2;
    end
  end
  expLineErr.push_back(corrupt != corNone);
endtask

// Z line, only its checksum matters
task automatic buildZLine(input bit badSum);
  int n;
  n = $urandom % 4;
  lineWords.delete();
  lineWords.push_back(loadWordT'(n));
  lineWords.push_back(loadWordT'($urandom));
  repeat (n) begin
    lineWords.push_back(loadWordT'($urandom));
  end
  pushChecksum(badSum);
  emitLine(chLetterZ);
  expLineErr.push_back(badSum);
endtask

// "C ,," or "D ,," restarts that RAM's continuation at zero
task automatic buildEofLine(input recTypeT kind);
  lineChars.push_back((kind == recCram) ? chLetterC : chLetterD);
  lineChars.push_back(7'h20);
  lineChars.push_back(chComma);
  lineChars.push_back(chComma);
  appendEol();
  if (kind == recCram) begin
    modelCramPtr = '0;
  end else begin
    modelDramPtr = '0;
  end
  expLineErr.push_back(1'b0);
endtask

// Printable text, commas and data characters included
task automatic buildCommentLine();
  int n;
  lineChars.push_back(chSemi);
  n = $urandom % 24;
  repeat (n) begin
    lineChars.push_back(7'(32 + $urandom % 95));
  end
  appendEol();
  expLineErr.push_back(1'b0);
endtask

`endif

//--- bench/ucodeLoaderTb.sv
// Testbench for the microcode loader, random load lines checked against a model
`timescale 1ns/1ps

module ucodeLoaderTb;
  import ucodeFormatPkg::*;
  import ramMapPkg::*;

  localparam int clkPeriod = 20;
  localparam int resetCycles = 16;
  localparam int drainLimit = 2000;

  logic clk;
  logic rstN;
  logic charValid;
  logic [charBits-1:0] charIn;
  logic cramWe;
  cramAdrT cramAdr;
  cramEntryT cramData;
  logic dramWe;
  dramAdrT dramAdr;
  dramEntryT dramEven;
  dramEntryT dramOdd;
  logic lineDone;
  logic lineErr;

  // Bookkeeping
  int errorCount = 0;
  int checkCount = 0;
  int testErrors = 0;
  int testsRun = 0;
  int testsFailed = 0;
  bit timedOut = 1'b0;

  `include "loadModel.svh"

  ucodeLoader uut (
    .clk     (clk),
    .rstN    (rstN),
    .charValid(charValid),
    .charIn  (charIn),
    .cramWe  (cramWe),
    .cramAdr (cramAdr),
    .cramData(cramData),
    .dramWe  (dramWe),
    .dramAdr (dramAdr),
    .dramEven(dramEven),
    .dramOdd (dramOdd),
    .lineDone(lineDone),
    .lineErr (lineErr)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic checkValue(input string what, input logic [127:0] got,
                            input logic [127:0] exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      testErrors++;
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic flagUnexpected(input string what);
    errorCount++;
    testErrors++;
    $display("At %0t ns the DUT gave %s that the model did not predict", $time, what);
  endtask

  //////////////////////////////////////////////////
  // Output monitors, sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rstN && cramWe !== 1'b0) begin
      if (expCramAdr.size() == 0) begin
        flagUnexpected("a CRAM write");
      end else begin
        checkValue("cramAdr", cramAdr, expCramAdr.pop_front());
        checkValue("cramData", cramData, expCramData.pop_front());
      end
    end
  end

  always @(negedge clk) begin
    if (rstN && dramWe !== 1'b0) begin
      if (expDramAdr.size() == 0) begin
        flagUnexpected("a DRAM write");
      end else begin
        checkValue("dramAdr", dramAdr, expDramAdr.pop_front());
        checkValue("dramEven", dramEven, expDramEven.pop_front());
        checkValue("dramOdd", dramOdd, expDramOdd.pop_front());
      end
    end
  end

  always @(negedge clk) begin
    if (rstN && lineDone !== 1'b0) begin
      if (expLineErr.size() == 0) begin
        flagUnexpected("a line status");
      end else begin
        checkValue("lineErr", lineErr, expLineErr.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // One character per rising edge, then zero to maxGap idle cycles
  task automatic sendLine(input int maxGap);
    int gap;
    logic [charBits-1:0] c;
    while (lineChars.size() > 0) begin
      c = lineChars.pop_front();
      @(posedge clk);
      charValid <= 1'b1;
      charIn <= c;
      gap = $urandom % (maxGap + 1);
      repeat (gap) begin
        @(posedge clk);
        charValid <= 1'b0;
      end
    end
  endtask

  function automatic recTypeT randKind();
    return ($urandom % 2 == 0) ? recCram : recDram;
  endfunction

  // C lines of one to five locations, D lines of one to ten pairs
  task automatic ramLine(input recTypeT kind, input bit cont, input int corrupt,
                         input int maxGap);
    int groups;
    groups = (kind == recCram) ? 1 + $urandom % 5 : 1 + $urandom % 10;
    buildRamLine(kind, groups, cont, corrupt);
    sendLine(maxGap);
  endtask

  function automatic int pending();
    return expCramAdr.size() + expDramAdr.size() + expLineErr.size();
  endfunction

  // Wait for the queues to drain, then report the test
  task automatic finishTest(input string name);
    int cycles;
    @(posedge clk);
    charValid <= 1'b0;
    cycles = 0;
    while (pending() != 0 && cycles < drainLimit) begin
      @(posedge clk);
      cycles++;
    end
    if (pending() != 0) begin
      timedOut = 1'b1;
      errorCount++;
      testErrors++;
      $display("Timeout in %s, %0d predicted outputs never came", name, pending());
    end
    // Late extra outputs still get caught here
    repeat (4) @(posedge clk);
    testsRun++;
    if (testErrors == 0) begin
      $display("Test %0d %s: passed", testsRun, name);
    end else begin
      testsFailed++;
      $display("Test %0d %s: failed, %0d errors", testsRun, name, testErrors);
    end
    testErrors = 0;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int corrupt;
    void'($urandom(32'h3e08_6459));
    rstN = 1'b0;
    charValid = 1'b0;
    charIn = '0;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
    repeat (2) @(posedge clk);

    repeat (20) ramLine(recCram, 1'b0, corNone, 2);
    finishTest("random C lines");

    if (!timedOut) begin
      repeat (20) ramLine(recDram, 1'b0, corNone, 2);
      finishTest("random D lines");
    end

    if (!timedOut) begin
      // Continuation per type, EOF line restarts only its own type
      repeat (3) begin
        ramLine(recCram, 1'b0, corNone, 2);
        ramLine(recCram, 1'b1, corNone, 2);
        ramLine(recDram, 1'b0, corNone, 2);
        ramLine(recCram, 1'b1, corNone, 2);
        ramLine(recDram, 1'b1, corNone, 2);
        buildEofLine(recCram);
        sendLine(2);
        ramLine(recCram, 1'b1, corNone, 2);
        ramLine(recDram, 1'b1, corNone, 2);
        buildEofLine(recDram);
        sendLine(2);
        ramLine(recDram, 1'b1, corNone, 2);
      end
      finishTest("address continuation");
    end

    if (!timedOut) begin
      // Each bad line followed by a good one that continues
      repeat (24) begin
        corrupt = 1 + $urandom % 4;
        ramLine(randKind(), $urandom % 2, corrupt, 2);
        ramLine(randKind(), 1'b1, corNone, 2);
      end
      finishTest("corrupted lines");
    end

    if (!timedOut) begin
      repeat (30) begin
        case ($urandom % 3)
          0: buildCommentLine();
          1: buildZLine($urandom % 2);
          default: buildRamLine(randKind(), 1 + $urandom % 2, 1'b1, corNone);
        endcase
        sendLine(2);
      end
      finishTest("comment and Z lines");
    end

    if (!timedOut) begin
      // No idle cycles inside or between lines
      repeat (24) ramLine(randKind(), $urandom % 2, corNone, 0);
      finishTest("back-to-back characters");
    end

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             testsRun, testsFailed, checkCount, errorCount);
    if (testsFailed == 0 && errorCount == 0 && !timedOut) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- ucodeLoader.f
+incdir+bench
hw/ucodeFormatPkg.sv
hw/ramMapPkg.sv
hw/charClassifier.sv
hw/fieldAssembler.sv
hw/recordParser.sv
hw/ucodeLoader.sv
bench/ucodeLoaderTb.sv
